// ==== Makefile ====
TOP := tb_fft

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o sim_fft
	./obj_dir/sim_fft | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== fft_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module fft_checker
  import fft_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input logic [8*12-1:0] test_name,
  input sample_t         in_sample,
  input logic            in_val,
  input logic            in_rdy,
  input sample_t         out_re,
  input sample_t         out_im,
  input logic            out_last,
  input logic            out_val,
  input logic            out_rdy
);

  // Rounded Q8.8 cos and -sin of 2*pi*k/8
  int tw_re [`FFT_N/2] = '{256, 181, 0, -181};
  int tw_im [`FFT_N/2] = '{0, -181, -256, -181};

  sample_t         in_buf [`FFT_N];
  cplx_t           exp_q [$];
  logic [8*12-1:0] name_q [$];
  int              in_cnt, out_pos;
  int              mism_cnt = 0;
  int              other_cnt = 0;
  int              bins_seen = 0;

  function automatic int wrap16(input int v);
    return int'(shortint'(v));
  endfunction

  function automatic int qmul(input int a, input int b);
    return (a * b) >>> `FFT_FRAC;  // Floor
  endfunction

  function automatic int rev_index(input int i);
    int r;
    r = 0;
    for (int b = 0; b < `FFT_LOG2N; b++) r = (r << 1) | ((i >> b) & 1);
    return r;
  endfunction

  // Radix-2 DIT on the bit-reversed frame, results queued in bin order
  task automatic run_model(input logic [8*12-1:0] nm);
    int re [`FFT_N];
    int im [`FFT_N];
    int span, top, bot, k, xr, xi;
    for (int i = 0; i < `FFT_N; i++) begin
      re[rev_index(i)] = in_buf[i];
      im[rev_index(i)] = 0;
    end
    for (int s = 0; s < `FFT_LOG2N; s++) begin
      span = 1 << s;
      for (int g = 0; g < `FFT_N; g += 2 * span) begin
        for (int p = 0; p < span; p++) begin
          top     = g + p;
          bot     = top + span;
          k       = p * `FFT_N / (2 * span);
          xr      = qmul(tw_re[k], re[bot]) - qmul(tw_im[k], im[bot]);
          xi      = qmul(tw_re[k], im[bot]) + qmul(tw_im[k], re[bot]);
          re[bot] = wrap16(re[top] - xr);
          im[bot] = wrap16(im[top] - xi);
          re[top] = wrap16(re[top] + xr);
          im[top] = wrap16(im[top] + xi);
        end
      end
    end
    for (int i = 0; i < `FFT_N; i++) begin
      exp_q.push_back('{re: sample_t'(re[i]), im: sample_t'(im[i])});
      name_q.push_back(nm);
    end
  endtask

  always @(posedge clk) begin
    cplx_t           e;
    logic [8*12-1:0] nm;
    if (!rst_n) begin
      in_cnt  = 0;
      out_pos = 0;
    end else begin
      if (in_val && in_rdy) begin
        in_buf[in_cnt] = in_sample;
        in_cnt++;
        if (in_cnt == `FFT_N) begin
          run_model(test_name);
          in_cnt = 0;
        end
      end
      if (out_val && out_rdy) begin
        bins_seen++;
        if (exp_q.size() == 0) begin
          $display("bin %0d came out with no input frame behind it", out_pos);
          other_cnt++;
        end else begin
          e  = exp_q.pop_front();
          nm = name_q.pop_front();
          if (out_re !== e.re || out_im !== e.im) begin
            $display("mismatch %0s bin %0d: expected (%0d, %0d), actual (%0d, %0d)",
                     nm, out_pos, e.re, e.im, out_re, out_im);
            mism_cnt++;
          end
          if (out_pos == `FFT_N - 1 && !out_last) begin
            $display("out_last missing on the last bin of %0s", nm);
            other_cnt++;
          end else if (out_pos != `FFT_N - 1 && out_last) begin
            $display("out_last raised early on bin %0d of %0s", out_pos, nm);
            other_cnt++;
          end
        end
        out_pos = (out_pos + 1) % `FFT_N;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fft_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

// Expects the input frame already in bit-reversed order
module fft_core
  import fft_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  fft_stream_if.sink   frame_in,
  fft_stream_if.source frame_out
);

  fft_stream_if #(.payload_t(frame_t)) link [`FFT_LOG2N+1] ();

  bin_idx_t tw_k [`FFT_LOG2N][`FFT_N/2];
  cplx_t    tw   [`FFT_LOG2N][`FFT_N/2];

  assign link[0].val  = frame_in.val;
  assign link[0].data = frame_in.data;
  assign frame_in.rdy = link[0].rdy;

  assign frame_out.val            = link[`FFT_LOG2N].val;
  assign frame_out.data           = link[`FFT_LOG2N].data;
  assign link[`FFT_LOG2N].rdy     = frame_out.rdy;

  for (genvar s = 0; s < `FFT_LOG2N; s++) begin : g_stage
    fft_stage #(
      .STAGE(s)
    ) u_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .frame_in (link[s]),
      .frame_out(link[s+1]),
      .tw_k     (tw_k[s]),
      .tw       (tw[s])
    );

    for (genvar b = 0; b < `FFT_N/2; b++) begin : g_rom
      fft_twiddle_rom u_rom (
        .k(tw_k[s][b]),
        .w(tw[s][b])
      );
    end
  end

endmodule

`default_nettype wire

// ==== fft_defs.svh ====
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

`define FFT_N      8   // Points per frame
`define FFT_W      16  // Sample width, Q8.8
`define FFT_FRAC   8   // Fraction bits
`define FFT_LOG2N  3   // Butterfly stages

`endif

// ==== fft_frame_unloader.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module fft_frame_unloader
  import fft_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  fft_stream_if.sink frame_in,
  output sample_t    out_re,
  output sample_t    out_im,
  output logic       out_last,
  output logic       out_val,
  input  logic       out_rdy
);

  localparam bin_idx_t LAST = bin_idx_t'(`FFT_N - 1);

  frame_t   frame_q;
  bin_idx_t cnt;     // Bin on offer
  logic     full;

  assign frame_in.rdy = !full;
  assign out_val      = full;
  assign out_re       = frame_q[cnt].re;
  assign out_im       = frame_q[cnt].im;
  assign out_last     = full && (cnt == LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
      cnt  <= '0;
    end else if (frame_in.val && frame_in.rdy) begin
      full <= 1'b1;
      cnt  <= '0;
    end else if (out_val && out_rdy) begin
      cnt <= cnt + 1'b1;
      if (out_last) begin
        full <= 1'b0;  // Free after the last bin
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_in.val && frame_in.rdy) begin
      frame_q <= frame_in.data;
    end
  end

  // Offered bin and its flag hold until taken
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_val && !out_rdy) |=> (out_val && $stable({out_re, out_im, out_last})));

endmodule

`default_nettype wire

// ==== fft_pkg.sv ====
`default_nettype none

`include "fft_defs.svh"

package fft_pkg;

  typedef logic signed [`FFT_W-1:0] sample_t;  // Q8.8

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  typedef cplx_t [`FFT_N-1:0] frame_t;  // Whole frame, point 0 in the low slot

  typedef logic [`FFT_LOG2N-1:0] bin_idx_t;

endpackage

`default_nettype wire

// ==== fft_sample_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module fft_sample_loader
  import fft_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  sample_t      in_sample,
  input  logic         in_val,
  output logic         in_rdy,
  fft_stream_if.source frame_out
);

  localparam bin_idx_t LAST = bin_idx_t'(`FFT_N - 1);

  function automatic bin_idx_t bit_rev(input bin_idx_t i);
    bin_idx_t r;
    for (int b = 0; b < `FFT_LOG2N; b++) begin
      r[b] = i[`FFT_LOG2N-1-b];
    end
    return r;
  endfunction

  bin_idx_t wr_cnt;
  logic     pend;     // Full frame waiting for the core
  frame_t   frame_q;

  assign in_rdy         = !pend;
  assign frame_out.val  = pend;
  assign frame_out.data = frame_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      pend   <= 1'b0;
    end else if (in_val && in_rdy) begin
      wr_cnt <= wr_cnt + 1'b1;
      if (wr_cnt == LAST) begin
        pend <= 1'b1;
      end
    end else if (frame_out.val && frame_out.rdy) begin
      pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      frame_q[bit_rev(wr_cnt)] <= '{re: in_sample, im: '0};  // Real input only
    end
  end

  // Pending frame is neither dropped nor overwritten by new samples
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    (frame_out.val && !frame_out.rdy) |=> (frame_out.val && $stable(frame_out.data)));

endmodule

`default_nettype wire

// ==== fft_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module fft_stage
  import fft_pkg::*;
#(
  parameter int STAGE = 0
) (
  input  logic         clk,
  input  logic         rst_n,
  fft_stream_if.sink   frame_in,
  fft_stream_if.source frame_out,
  output bin_idx_t     tw_k [`FFT_N/2],
  input  cplx_t        tw   [`FFT_N/2]
);

  localparam int SPAN    = 1 << STAGE;
  localparam int TW_STEP = `FFT_N / (2 * SPAN);

  // Full-width product, floor shift back to Q8.8
  function automatic sample_t mul_q(input sample_t x, input sample_t y);
    logic signed [2*`FFT_W-1:0] p;
    p = x * y;
    return sample_t'(p >>> `FFT_FRAC);
  endfunction

  wire frame_t res;
  frame_t      slot_q;
  logic        full;

  for (genvar b = 0; b < `FFT_N/2; b++) begin : g_bfly
    localparam int GRP = b / SPAN;
    localparam int POS = b % SPAN;
    localparam int TOP = GRP * 2 * SPAN + POS;
    localparam int BOT = TOP + SPAN;

    cplx_t a;
    cplx_t x;
    cplx_t wx;

    assign tw_k[b] = bin_idx_t'(POS * TW_STEP);
    assign a       = frame_in.data[TOP];
    assign x       = frame_in.data[BOT];

    assign wx = '{re: mul_q(tw[b].re, x.re) - mul_q(tw[b].im, x.im),
                  im: mul_q(tw[b].re, x.im) + mul_q(tw[b].im, x.re)};

    // Sums wrap to 16 bits
    assign res[TOP] = '{re: a.re + wx.re, im: a.im + wx.im};
    assign res[BOT] = '{re: a.re - wx.re, im: a.im - wx.im};
  end

  assign frame_in.rdy   = !full || frame_out.rdy;
  assign frame_out.val  = full;
  assign frame_out.data = slot_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (frame_in.val && frame_in.rdy) begin
      full <= 1'b1;
    end else if (frame_out.rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_in.val && frame_in.rdy) begin
      slot_q <= res;
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (frame_out.val && !frame_out.rdy) |=> (frame_out.val && $stable(frame_out.data)));

endmodule

`default_nettype wire

// ==== fft_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface fft_stream_if #(
  parameter type payload_t = logic
) ();

  logic     val;
  logic     rdy;
  payload_t data;

  modport source (
    output val,
    output data,
    input  rdy
  );

  modport sink (
    input  val,
    input  data,
    output rdy
  );

endinterface

`default_nettype wire

// ==== fft_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft_top
  import fft_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t in_sample,
  input  logic    in_val,
  output logic    in_rdy,
  output sample_t out_re,
  output sample_t out_im,
  output logic    out_last,
  output logic    out_val,
  input  logic    out_rdy
);

  fft_stream_if #(.payload_t(frame_t)) ld2core ();
  fft_stream_if #(.payload_t(frame_t)) core2ul ();

  fft_sample_loader u_loader (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_sample(in_sample),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .frame_out(ld2core)
  );

  fft_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .frame_in (ld2core),
    .frame_out(core2ul)
  );

  fft_frame_unloader u_unloader (
    .clk     (clk),
    .rst_n   (rst_n),
    .frame_in(core2ul),
    .out_re  (out_re),
    .out_im  (out_im),
    .out_last(out_last),
    .out_val (out_val),
    .out_rdy (out_rdy)
  );

endmodule

`default_nettype wire

// ==== fft_twiddle_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module fft_twiddle_rom
  import fft_pkg::*;
(
  input  bin_idx_t k,
  output cplx_t    w
);

  // Nearest Q8.8 value of cos or -sin of 2*pi*idx/N
  function automatic sample_t tw_val(input int idx, input bit imag);
    real ang;
    real v;
    ang = 2.0 * 3.14159265358979 * idx / `FFT_N;
    v   = imag ? -$sin(ang) : $cos(ang);
    v   = v * (1 << `FFT_FRAC);
    return sample_t'($rtoi($floor(v + 0.5)));
  endfunction

  cplx_t table_w [`FFT_N];

  for (genvar i = 0; i < `FFT_N; i++) begin : g_tab
    localparam sample_t TW_RE = tw_val(i, 1'b0);
    localparam sample_t TW_IM = tw_val(i, 1'b1);
    assign table_w[i] = '{re: TW_RE, im: TW_IM};
  end

  assign w = table_w[k];  // Only k < N/2 is used by the stages

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
fft_pkg.sv
fft_stream_if.sv
fft_twiddle_rom.sv
fft_sample_loader.sv
fft_stage.sv
fft_core.sv
fft_frame_unloader.sv
fft_top.sv
fft_checker.sv
tb_fft.sv

// ==== tb_fft.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fft_defs.svh"

module tb_fft
  import fft_pkg::*;
();

  localparam int PERIOD   = 20;
  localparam int NROWS    = 8;
  localparam int WDOG_CYC = NROWS * 64 + 200;

  typedef struct packed {
    logic [8*12-1:0]               name;
    logic [0:`FFT_N-1][`FFT_W-1:0] smp;
    logic                          rnd;    // Samples come from the LFSR
    logic                          stall;  // Random out_rdy
  } row_t;

  localparam row_t TESTS [NROWS] = '{
    '{"impulse", {16'h0100, {7{16'h0}}}, 1'b0, 1'b0},
    '{"dc", {8{16'h0040}}, 1'b0, 1'b0},
    '{"alternating", {4{16'h0040, 16'hffc0}}, 1'b0, 1'b0},
    '{"rand_a", {8{16'h0}}, 1'b1, 1'b0},
    '{"rand_b", {8{16'h0}}, 1'b1, 1'b0},
    '{"rand_stall_a", {8{16'h0}}, 1'b1, 1'b1},
    '{"imp_stall", {16'h0100, {7{16'h0}}}, 1'b0, 1'b1},
    '{"rand_stall_b", {8{16'h0}}, 1'b1, 1'b1}
  };

  logic            clk, rst_n, in_val, in_rdy, out_last, out_val, out_rdy, stall_on;
  sample_t         in_sample, out_re, out_im;
  logic [8*12-1:0] test_name;
  logic [31:0]     lfsr_q;
  row_t            rows [NROWS];
  int              reset_err = 0;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[14:0], fb};
    end
    return v;
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_sample(input logic [8*12-1:0] nm, input logic [15:0] s);
    test_name = nm;
    in_sample = s;
    in_val    = 1'b1;
    while (!in_rdy) @(negedge clk);
    @(negedge clk);
  endtask

  fft_top u_dut (
    .clk(clk), .rst_n(rst_n), .in_sample(in_sample), .in_val(in_val), .in_rdy(in_rdy),
    .out_re(out_re), .out_im(out_im), .out_last(out_last), .out_val(out_val),
    .out_rdy(out_rdy)
  );

  fft_checker u_chk (
    .clk(clk), .rst_n(rst_n), .test_name(test_name), .in_sample(in_sample),
    .in_val(in_val), .in_rdy(in_rdy), .out_re(out_re), .out_im(out_im),
    .out_last(out_last), .out_val(out_val), .out_rdy(out_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    out_rdy = 1'b1;
    wait (rst_n);
    forever begin
      @(negedge clk);
      out_rdy = stall_on ? (rand_bits(1) != 0) : 1'b1;
    end
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("timeout after %0d cycles, output frames did not complete", WDOG_CYC);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    in_val    = 1'b0;
    in_sample = '0;
    test_name = '0;
    stall_on  = 1'b0;
    lfsr_q    = 32'h0bdd_91b6;
    for (int r = 0; r < NROWS; r++) begin
      rows[r] = TESTS[r];
      for (int i = 0; i < `FFT_N; i++) begin
        if (rows[r].rnd) rows[r].smp[i] = rand_bits(16);
      end
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (out_val !== 1'b0 || in_rdy !== 1'b1) begin
      $display("after reset out_val is not low or in_rdy is not high");
      reset_err++;
    end
    for (int r = 0; r < NROWS; r++) begin
      stall_on <= rows[r].stall;
      for (int i = 0; i < `FFT_N; i++) send_sample(rows[r].name, rows[r].smp[i]);
    end
    in_val = 1'b0;
    while (u_chk.bins_seen < NROWS * `FFT_N) @(negedge clk);
    repeat (20) @(negedge clk);  // Catch stray extra bins
    $display("bins %0d of %0d, mismatches %0d, other errors %0d", u_chk.bins_seen,
             NROWS * `FFT_N, u_chk.mism_cnt, u_chk.other_cnt + reset_err);
    if (u_chk.mism_cnt + u_chk.other_cnt + reset_err == 0 &&
        u_chk.bins_seen == NROWS * `FFT_N) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
